/* sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

  localparam int clk_mhz = 100;
  localparam int clk_period_ns = 1000 / clk_mhz;

  // host side
  localparam int addr_width = 24;  // 32-bit word address
  localparam int data_width = 32;

  // device side, single x16 rank
  localparam int sdram_addr_width = 13;
  localparam int sdram_data_width = 16;
  localparam int col_width = 10;
  localparam int row_width = 13;
  localparam int bank_width = 2;
  localparam int burst_length = 2;
  localparam int cas_latency = 2;

  // datasheet figures in ns
  localparam int t_desl_ns = 100000;  // power-up delay
  localparam int t_mrd_ns = 14;
  localparam int t_rc_ns = 60;
  localparam int t_rcd_ns = 15;
  localparam int t_rp_ns = 15;
  localparam int t_wr_ns = 15;
  localparam int t_refi_ns = 7800;  // average refresh period

  // waits in clock cycles, rounded up
  localparam int init_wait = (t_desl_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int precharge_wait = (t_rp_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int refresh_wait = (t_rc_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int load_mode_wait = (t_mrd_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int active_wait = (t_rcd_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int read_wait = cas_latency + burst_length;
  localparam int write_wait =
      burst_length + (t_wr_ns + t_rp_ns + clk_period_ns - 1) / clk_period_ns;
  localparam int refresh_interval = t_refi_ns / clk_period_ns - 10;  // keep some margin

  localparam int wait_cnt_width = 14;  // covers the whole init schedule

  // all banks on precharge, auto-precharge on read/write
  localparam int auto_precharge_bit = 10;

  // burst write, cas latency, sequential burst, burst length code
  localparam logic [sdram_addr_width-1:0] mode_reg_value = {
    3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'($clog2(burst_length))
  };

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_deselect     = 4'hf,
    cmd_load_mode    = 4'h0,
    cmd_auto_refresh = 4'h1,
    cmd_precharge    = 4'h2,
    cmd_active       = 4'h3,
    cmd_write        = 4'h4,
    cmd_read         = 4'h5,
    cmd_nop          = 4'h7
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    st_init,
    st_mode,
    st_idle,
    st_active,
    st_read,
    st_write,
    st_refresh
  } seq_state_e;

endpackage

`default_nettype wire

/* sdram_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// latched host request, shared by sequencer and data path
interface sdram_req_if;

  logic [sdram_pkg::bank_width-1:0]   bank;
  logic [sdram_pkg::row_width-1:0]    row;
  logic [sdram_pkg::col_width-1:0]    col;  // half-word column
  logic [sdram_pkg::data_width-1:0]   data;
  logic [sdram_pkg::data_width/8-1:0] byte_mask;  // 1 masks the byte
  logic                               we;

  modport source(output bank, row, col, data, byte_mask, we);

  modport seq(input bank, row, col, we);

  modport dp(input data, byte_mask);

endinterface

`default_nettype wire

/* sdram_beat_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sdram_beat_if;

  logic wr_beat;   // write data on dq this cycle
  logic rd_beat;   // capture dq at end of this cycle
  logic beat_sel;  // 0 low half-word, 1 high
  logic rd_last;

  modport seq(output wr_beat, rd_beat, beat_sel, rd_last);

  modport dp(input wr_beat, rd_beat, beat_sel, rd_last);

endinterface

`default_nettype wire

/* sdram_request_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_request_reg (
  input  wire                                    clk,
  input  wire                                    start,
  input  wire  [sdram_pkg::addr_width-1:0]       addr,
  input  wire  [sdram_pkg::data_width-1:0]       data,
  input  wire  [sdram_pkg::data_width/8-1:0]     bwe,
  input  wire                                    we,
  sdram_req_if.source                            req_bus
);

  // word address is {bank, row, word column}
  always_ff @(posedge clk) begin
    if (start) begin
      req_bus.bank <= addr[sdram_pkg::addr_width-1 -: sdram_pkg::bank_width];
      req_bus.row  <= addr[sdram_pkg::col_width-1 +: sdram_pkg::row_width];
      // two half-words per 32-bit word
      req_bus.col  <= {addr[sdram_pkg::col_width-2:0], 1'b0};
      req_bus.data <= data;
      req_bus.byte_mask <= ~bwe;  // dqm is active high
      req_bus.we   <= we;
    end
  end

endmodule

`default_nettype wire

/* sdram_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_sequencer (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire                                         req,
  output logic                                        ack,
  output logic                                        start,
  output sdram_pkg::sdram_cmd_e                       cmd,
  output logic [sdram_pkg::sdram_addr_width-1:0]      sdram_a,
  output logic [sdram_pkg::bank_width-1:0]            sdram_ba,
  output logic                                        sdram_cke,
  sdram_req_if.seq                                    req_bus,
  sdram_beat_if.seq                                   beats
);

  sdram_pkg::seq_state_e state;
  sdram_pkg::seq_state_e next_state;
  sdram_pkg::sdram_cmd_e next_cmd;

  logic [sdram_pkg::wait_cnt_width-1:0] wait_cnt;
  logic [sdram_pkg::wait_cnt_width-1:0] refresh_cnt;
  logic [sdram_pkg::wait_cnt_width-1:0] rd_idx;  // read beat index

  logic load_mode_done;
  logic active_done;
  logic op_done;
  logic should_refresh;

  assign load_mode_done = wait_cnt == sdram_pkg::load_mode_wait - 1;
  assign active_done    = wait_cnt == sdram_pkg::active_wait - 1;
  assign should_refresh = refresh_cnt >= sdram_pkg::refresh_interval - 1;

  // end of a read, write or refresh
  assign op_done =
      (state == sdram_pkg::st_read && wait_cnt == sdram_pkg::read_wait - 1) ||
      (state == sdram_pkg::st_write && wait_cnt == sdram_pkg::write_wait - 1) ||
      (state == sdram_pkg::st_refresh && wait_cnt == sdram_pkg::refresh_wait - 1);

  assign start = state == sdram_pkg::st_idle || op_done;

  always_comb begin
    next_state = state;
    next_cmd   = sdram_pkg::cmd_nop;
    case (state)
      sdram_pkg::st_init: begin
        if (wait_cnt == 0)
          next_cmd = sdram_pkg::cmd_deselect;
        if (wait_cnt == sdram_pkg::init_wait - 1)
          next_cmd = sdram_pkg::cmd_precharge;
        if (wait_cnt == sdram_pkg::init_wait + sdram_pkg::precharge_wait - 1)
          next_cmd = sdram_pkg::cmd_auto_refresh;
        if (wait_cnt == sdram_pkg::init_wait + sdram_pkg::precharge_wait +
                        sdram_pkg::refresh_wait - 1)
          next_cmd = sdram_pkg::cmd_auto_refresh;
        if (wait_cnt == sdram_pkg::init_wait + sdram_pkg::precharge_wait +
                        2 * sdram_pkg::refresh_wait - 1) begin
          next_state = sdram_pkg::st_mode;
          next_cmd   = sdram_pkg::cmd_load_mode;
        end
      end
      sdram_pkg::st_mode: begin
        if (load_mode_done) next_state = sdram_pkg::st_idle;
      end
      sdram_pkg::st_active: begin
        if (active_done) begin
          if (req_bus.we) begin
            next_state = sdram_pkg::st_write;
            next_cmd   = sdram_pkg::cmd_write;
          end else begin
            next_state = sdram_pkg::st_read;
            next_cmd   = sdram_pkg::cmd_read;
          end
        end
      end
      sdram_pkg::st_idle, sdram_pkg::st_read, sdram_pkg::st_write, sdram_pkg::st_refresh: begin
        // refresh wins over a waiting request
        if (start) begin
          if (should_refresh) begin
            next_state = sdram_pkg::st_refresh;
            next_cmd   = sdram_pkg::cmd_auto_refresh;
          end else if (req) begin
            next_state = sdram_pkg::st_active;
            next_cmd   = sdram_pkg::cmd_active;
          end else begin
            next_state = sdram_pkg::st_idle;
          end
        end
      end
      default: next_state = sdram_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= sdram_pkg::st_init;
      cmd   <= sdram_pkg::cmd_nop;
    end else begin
      state <= next_state;
      cmd   <= next_cmd;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      wait_cnt <= '0;
    else if (state != next_state)
      wait_cnt <= '0;
    else
      wait_cnt <= wait_cnt + 1'b1;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      refresh_cnt <= '0;
    else if (state == sdram_pkg::st_refresh && wait_cnt == 0)
      refresh_cnt <= '0;
    else
      refresh_cnt <= refresh_cnt + 1'b1;
  end

  assign ack       = state == sdram_pkg::st_active && wait_cnt == 0;
  assign sdram_cke = !(state == sdram_pkg::st_init && wait_cnt == 0);  // low one cycle

  // data shows up cas_latency cycles after the read command
  assign rd_idx = wait_cnt - sdram_pkg::wait_cnt_width'(sdram_pkg::cas_latency);

  assign beats.wr_beat  = state == sdram_pkg::st_write && wait_cnt < sdram_pkg::burst_length;
  assign beats.rd_beat  = state == sdram_pkg::st_read && wait_cnt >= sdram_pkg::cas_latency &&
                          wait_cnt < sdram_pkg::read_wait;
  assign beats.beat_sel = wait_cnt[0];  // low half on even counts
  assign beats.rd_last  = beats.rd_beat && rd_idx == sdram_pkg::burst_length - 1;

  always_comb begin
    sdram_a  = '0;
    sdram_ba = '0;
    case (state)
      sdram_pkg::st_init: sdram_a[sdram_pkg::auto_precharge_bit] = 1'b1;  // precharge all
      sdram_pkg::st_mode: sdram_a = sdram_pkg::mode_reg_value;
      sdram_pkg::st_active: begin
        sdram_a[sdram_pkg::row_width-1:0] = req_bus.row;
        sdram_ba = req_bus.bank;
      end
      sdram_pkg::st_read, sdram_pkg::st_write: begin
        sdram_a[sdram_pkg::col_width-1:0] = req_bus.col;
        sdram_a[sdram_pkg::auto_precharge_bit] = 1'b1;  // auto-precharge
        sdram_ba = req_bus.bank;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* sdram_data_path.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_data_path (
  input  wire                                    clk,
  input  wire                                    reset,
  sdram_req_if.dp                                req_bus,
  sdram_beat_if.dp                               beats,
  inout  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq,
  output logic                                   sdram_dqml,
  output logic                                   sdram_dqmh,
  output logic [sdram_pkg::data_width-1:0]       q,
  output logic                                   valid
);

  logic [sdram_pkg::sdram_data_width-1:0] wr_half;
  logic [1:0]                             wr_mask;  // {dqmh, dqml}

  assign wr_half = beats.beat_sel ?
                   req_bus.data[sdram_pkg::sdram_data_width +: sdram_pkg::sdram_data_width] :
                   req_bus.data[0 +: sdram_pkg::sdram_data_width];
  assign wr_mask = beats.beat_sel ? req_bus.byte_mask[3:2] : req_bus.byte_mask[1:0];

  // only drive dq while a write beat is on the bus
  assign sdram_dq = beats.wr_beat ? wr_half : 'z;

  always_comb begin
    if (beats.wr_beat)
      {sdram_dqmh, sdram_dqml} = wr_mask;
    else if (beats.rd_beat)
      {sdram_dqmh, sdram_dqml} = 2'b00;
    else
      {sdram_dqmh, sdram_dqml} = 2'b11;  // masked when idle
  end

  // low half-word comes first
  always_ff @(posedge clk) begin
    if (beats.rd_beat) begin
      if (beats.beat_sel)
        q[sdram_pkg::sdram_data_width +: sdram_pkg::sdram_data_width] <= sdram_dq;
      else
        q[0 +: sdram_pkg::sdram_data_width] <= sdram_dq;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      valid <= 1'b0;
    else
      valid <= beats.rd_last;  // word complete
  end

endmodule

`default_nettype wire

/* sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire  [sdram_pkg::addr_width-1:0]       addr,
  input  wire  [sdram_pkg::data_width-1:0]       data,
  input  wire  [sdram_pkg::data_width/8-1:0]     bwe,
  input  wire                                    we,
  input  wire                                    req,
  output logic                                   ack,
  output logic                                   valid,
  output logic [sdram_pkg::data_width-1:0]       q,
  output logic [sdram_pkg::sdram_addr_width-1:0] sdram_a,
  output logic [sdram_pkg::bank_width-1:0]       sdram_ba,
  inout  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq,
  output logic                                   sdram_cke,
  output logic                                   sdram_cs_n,
  output logic                                   sdram_ras_n,
  output logic                                   sdram_cas_n,
  output logic                                   sdram_we_n,
  output logic                                   sdram_dqml,
  output logic                                   sdram_dqmh
);

  sdram_pkg::sdram_cmd_e cmd;
  logic                  start;

  sdram_req_if  req_bus ();
  sdram_beat_if beats ();

  sdram_request_reg request_reg_i (
    .clk     (clk),
    .start   (start),
    .addr    (addr),
    .data    (data),
    .bwe     (bwe),
    .we      (we),
    .req_bus (req_bus.source)
  );

  sdram_sequencer sequencer_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .ack       (ack),
    .start     (start),
    .cmd       (cmd),
    .sdram_a   (sdram_a),
    .sdram_ba  (sdram_ba),
    .sdram_cke (sdram_cke),
    .req_bus   (req_bus.seq),
    .beats     (beats.seq)
  );

  sdram_data_path data_path_i (
    .clk        (clk),
    .reset      (reset),
    .req_bus    (req_bus.dp),
    .beats      (beats.dp),
    .sdram_dq   (sdram_dq),
    .sdram_dqml (sdram_dqml),
    .sdram_dqmh (sdram_dqmh),
    .q          (q),
    .valid      (valid)
  );

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;

endmodule

`default_nettype wire

/* sdram_chip_model.sv */
`timescale 1ns/1ps
`default_nettype none

// behavioral x16 sdram, cl2 and burst 2 only
module sdram_chip_model (
  input  wire                                    clk,
  input  wire  [sdram_pkg::sdram_addr_width-1:0] sdram_a,
  input  wire  [sdram_pkg::bank_width-1:0]       sdram_ba,
  inout  wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq,
  input  wire                                    sdram_cke,
  input  wire                                    sdram_cs_n,
  input  wire                                    sdram_ras_n,
  input  wire                                    sdram_cas_n,
  input  wire                                    sdram_we_n,
  input  wire                                    sdram_dqml,
  input  wire                                    sdram_dqmh
);

  typedef logic [sdram_pkg::bank_width+sdram_pkg::row_width+sdram_pkg::col_width-1:0] key_t;

  sdram_pkg::sdram_cmd_e cmd;
  key_t                  key;
  key_t                  wr_key;
  logic                  wr_pend = 1'b0;
  int                    rd_cnt = 0;  // counts down through latency and burst
  int                    fault_count = 0;  // protocol violations seen

  logic [15:0]                    mem [key_t];  // sparse storage
  logic [15:0]                    rd_buf [sdram_pkg::burst_length];
  logic [sdram_pkg::row_width-1:0] open_row [1 << sdram_pkg::bank_width];
  logic [(1 << sdram_pkg::bank_width)-1:0] bank_open;

  function automatic logic [15:0] fetch(input key_t k);
    return mem.exists(k) ? mem[k] : 16'h0000;
  endfunction

  // byte lanes honour dqm
  task automatic store(input key_t k, input logic [15:0] d);
    logic [15:0] w;
    w = fetch(k);
    if (!sdram_dqml) w[7:0] = d[7:0];
    if (!sdram_dqmh) w[15:8] = d[15:8];
    mem[k] = w;
  endtask

  assign cmd = sdram_pkg::sdram_cmd_e'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});
  assign key = {sdram_ba, open_row[sdram_ba], sdram_a[sdram_pkg::col_width-1:0]};

  assign sdram_dq = (rd_cnt != 0 && rd_cnt <= sdram_pkg::burst_length) ?
                    rd_buf[sdram_pkg::burst_length - rd_cnt] : 'z;

  always @(posedge clk) begin
    if (rd_cnt != 0) rd_cnt <= rd_cnt - 1;
    if (wr_pend) begin
      store(wr_key, sdram_dq);  // second write beat
      wr_pend <= 1'b0;
    end
    if (sdram_cke) begin
      case (cmd)
        sdram_pkg::cmd_load_mode: begin
          if (sdram_a != sdram_pkg::mode_reg_value) begin
            fault_count++;
            $display("FAIL sdram_a: got %h expected %h in LOAD MODE", sdram_a,
                     sdram_pkg::mode_reg_value);
          end
        end
        sdram_pkg::cmd_active: begin
          open_row[sdram_ba]  <= sdram_a[sdram_pkg::row_width-1:0];
          bank_open[sdram_ba] <= 1'b1;
        end
        sdram_pkg::cmd_precharge: begin
          if (sdram_a[sdram_pkg::auto_precharge_bit]) bank_open <= '0;
          else bank_open[sdram_ba] <= 1'b0;
        end
        sdram_pkg::cmd_read: begin
          if (!bank_open[sdram_ba]) begin
            fault_count++;
            $display("sdram model: read from closed bank %0d", sdram_ba);
          end
          for (int b = 0; b < sdram_pkg::burst_length; b++)
            rd_buf[b] <= fetch(key ^ key_t'(b));  // sequential wrap
          rd_cnt <= sdram_pkg::cas_latency + sdram_pkg::burst_length - 1;
          if (sdram_a[sdram_pkg::auto_precharge_bit]) bank_open[sdram_ba] <= 1'b0;
        end
        sdram_pkg::cmd_write: begin
          if (!bank_open[sdram_ba]) begin
            fault_count++;
            $display("sdram model: write to closed bank %0d", sdram_ba);
          end
          store(key, sdram_dq);
          wr_key  <= key ^ key_t'(1);
          wr_pend <= 1'b1;
          if (sdram_a[sdram_pkg::auto_precharge_bit]) bank_open[sdram_ba] <= 1'b0;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb_sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl;

  localparam int ack_timeout = 100;
  localparam int valid_timeout = 100;
  localparam int init_timeout = 20000;
  localparam int refresh_limit = sdram_pkg::refresh_interval + 20;
  localparam int read_latency = sdram_pkg::active_wait + sdram_pkg::cas_latency + 2;

  // burst write, cas latency 2, sequential, burst length 2
  localparam logic [12:0] mode_word = 13'b000_0_00_010_0_001;

  logic        clk;
  logic        reset;
  logic [23:0] addr;
  logic [31:0] data;
  logic [3:0]  bwe;
  logic        we;
  logic        req;
  logic        ack;
  logic        valid;
  logic [31:0] q;
  logic [12:0] sdram_a;
  logic [1:0]  sdram_ba;
  wire  [15:0] sdram_dq;
  logic        sdram_cke;
  logic        sdram_cs_n;
  logic        sdram_ras_n;
  logic        sdram_cas_n;
  logic        sdram_we_n;
  logic        sdram_dqml;
  logic        sdram_dqmh;

  sdram_pkg::sdram_cmd_e pin_cmd;

  integer      seed;
  int          errors = 0;
  int          reads_checked = 0;
  logic        init_done = 1'b0;
  int          cyc = 0;
  int          last_ref = 0;
  logic        ref_seen = 1'b0;
  int          ref_count = 0;
  logic [23:0] act_addr;
  logic        act_we;
  logic [31:0] ref_mem [logic [23:0]];  // reference words by word address
  logic [23:0] written [$];
  logic [23:0] a;
  int          r0;

  sdram_ctrl sdram_ctrl_i (
    .clk(clk), .reset(reset), .addr(addr), .data(data), .bwe(bwe), .we(we), .req(req),
    .ack(ack), .valid(valid), .q(q), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
    .sdram_dq(sdram_dq), .sdram_cke(sdram_cke), .sdram_cs_n(sdram_cs_n),
    .sdram_ras_n(sdram_ras_n), .sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n),
    .sdram_dqml(sdram_dqml), .sdram_dqmh(sdram_dqmh)
  );

  sdram_chip_model chip_model_i (
    .clk(clk), .sdram_a(sdram_a), .sdram_ba(sdram_ba), .sdram_dq(sdram_dq),
    .sdram_cke(sdram_cke), .sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n),
    .sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n), .sdram_dqml(sdram_dqml),
    .sdram_dqmh(sdram_dqmh)
  );

  assign pin_cmd = sdram_pkg::sdram_cmd_e'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // word address is {bank, row, word column}
  function automatic logic [1:0] bank_of(input logic [23:0] wa);
    return wa[23:22];
  endfunction

  function automatic logic [12:0] row_of(input logic [23:0] wa);
    return wa[21:9];
  endfunction

  function automatic logic [9:0] col_of(input logic [23:0] wa);
    return {wa[8:0], 1'b0};  // half-word column
  endfunction

  function automatic logic [31:0] ref_word(input logic [23:0] wa);
    return ref_mem.exists(wa) ? ref_mem[wa] : 32'h0;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  en);
    logic [31:0] w;
    w = old_w;
    for (int i = 0; i < 4; i++)
      if (en[i]) w[8*i +: 8] = new_w[8*i +: 8];
    return w;
  endfunction

  function automatic logic [23:0] pick_written();
    return written[$unsigned($random(seed)) % written.size()];
  endfunction

  task automatic end_run();
    errors += chip_model_i.fault_count;
    $display("%0d reads checked, %0d errors", reads_checked, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout: %s", what);
    end_run();
  endtask

  // pin-level checks once the device is initialized
  always @(negedge clk) begin
    cyc++;
    if (init_done) begin
      case (pin_cmd)
        sdram_pkg::cmd_active: begin
          act_addr = addr;
          act_we = we;
          if (!ack) begin
            errors++;
            $display("ACTIVE issued in a cycle without ack (cycle %0d)", cyc);
          end
          if (sdram_ba !== bank_of(addr)) begin
            errors++;
            $display("FAIL sdram_ba: got %h expected %h", sdram_ba, bank_of(addr));
          end
          if (sdram_a !== row_of(addr)) begin
            errors++;
            $display("FAIL sdram_a: got %h expected %h", sdram_a, row_of(addr));
          end
        end
        sdram_pkg::cmd_read, sdram_pkg::cmd_write: begin
          if ((pin_cmd == sdram_pkg::cmd_write) != act_we) begin
            errors++;
            $display("command %s does not match the request type", pin_cmd.name());
          end
          if (sdram_ba !== bank_of(act_addr)) begin
            errors++;
            $display("FAIL sdram_ba: got %h expected %h", sdram_ba, bank_of(act_addr));
          end
          if (sdram_a !== {2'b00, 1'b1, col_of(act_addr)}) begin
            errors++;
            $display("FAIL sdram_a: got %h expected %h", sdram_a,
                     {2'b00, 1'b1, col_of(act_addr)});
          end
        end
        sdram_pkg::cmd_auto_refresh: begin
          if (ref_seen && cyc - last_ref > refresh_limit) begin
            errors++;
            $display("refresh came %0d cycles after the previous one", cyc - last_ref);
          end
          ref_seen = 1'b1;
          last_ref = cyc;
          ref_count++;
        end
        default: ;
      endcase
    end
  end

  task automatic check_power_up();
    int n;
    int step;
    n = 0;
    step = 0;
    while (step < 4 && n < init_timeout) begin
      @(negedge clk);
      n++;
      if (sdram_cke !== (n > 1)) begin
        errors++;
        $display("FAIL sdram_cke: got %h expected %h", sdram_cke, n > 1);
      end
      if (ack !== 1'b0) begin
        errors++;
        $display("ack raised before LOAD MODE");
      end
      if (pin_cmd != sdram_pkg::cmd_nop && pin_cmd != sdram_pkg::cmd_deselect) begin
        if (step == 0 && (pin_cmd != sdram_pkg::cmd_precharge || !sdram_a[10])) begin
          errors++;
          $display("expected PRECHARGE ALL, saw %s with a=%h", pin_cmd.name(), sdram_a);
        end
        if ((step == 1 || step == 2) && pin_cmd != sdram_pkg::cmd_auto_refresh) begin
          errors++;
          $display("expected AUTO REFRESH, saw %s", pin_cmd.name());
        end
        if (step == 3 && pin_cmd != sdram_pkg::cmd_load_mode) begin
          errors++;
          $display("expected LOAD MODE, saw %s", pin_cmd.name());
        end
        if (step == 3 && sdram_a !== mode_word) begin
          errors++;
          $display("FAIL sdram_a: got %h expected %h", sdram_a, mode_word);
        end
        step++;
      end
    end
    if (step < 4)
      report_timeout("power-up sequence did not finish");
    else
      init_done = 1'b1;
  endtask

  // waits for ack, then releases req
  task automatic wait_ack();
    int n;
    logic got;
    n = 0;
    got = 1'b0;
    while (!got && n < ack_timeout) begin
      @(negedge clk);
      n++;
      got = ack;
    end
    if (!got) begin
      report_timeout("no ack for request");
    end else begin
      @(posedge clk);
      #2;
      req = 1'b0;
    end
  endtask

  task automatic write_word(input logic [23:0] wa, input logic [31:0] wd, input logic [3:0] be);
    @(posedge clk);
    #2;
    req = 1'b1;
    we = 1'b1;
    addr = wa;
    data = wd;
    bwe = be;
    wait_ack();
    ref_mem[wa] = merge_bytes(ref_word(wa), wd, be);
  endtask

  task automatic read_word(input logic [23:0] ra);
    int n;
    logic got;
    @(posedge clk);
    #2;
    req = 1'b1;
    we = 1'b0;
    addr = ra;
    wait_ack();
    n = 0;  // cycles after the ack cycle
    got = 1'b0;
    while (!got && n < valid_timeout) begin
      @(negedge clk);
      n++;
      got = valid;
    end
    if (!got) begin
      report_timeout("no valid after read ack");
    end else begin
      reads_checked++;
      if (n != read_latency) begin
        errors++;
        $display("valid came %0d cycles after ack, expected %0d", n, read_latency);
      end
      if (q !== ref_word(ra)) begin
        errors++;
        $display("FAIL q: got %h expected %h at addr %h", q, ref_word(ra), ra);
      end
    end
  endtask

  task automatic wait_refresh();
    int n;
    logic got;
    n = 0;
    got = 1'b0;
    while (!got && n < refresh_limit + 100) begin
      @(negedge clk);
      n++;
      got = pin_cmd == sdram_pkg::cmd_auto_refresh;
    end
    if (!got) report_timeout("no AUTO REFRESH seen");
  endtask

  initial begin
    seed = 32'h16aa_de6c;
    reset = 1'b1;
    req = 1'b0;
    addr = '0;
    data = '0;
    bwe = '0;
    we = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    check_power_up();

    repeat (40) begin
      a = $random(seed);
      write_word(a, $random(seed), 4'hf);
      written.push_back(a);
    end
    repeat (40) read_word(pick_written());

    // byte-masked writes over existing words
    repeat (20) write_word(pick_written(), $random(seed), $random(seed));
    repeat (30) read_word(pick_written());

    r0 = ref_count;
    repeat (3 * sdram_pkg::refresh_interval) @(posedge clk);
    if (ref_count - r0 < 2) begin
      errors++;
      $display("only %0d refreshes during the idle stretch", ref_count - r0);
    end

    // mixed traffic, writes chain back to back
    repeat (150) begin
      if ($random(seed) & 1)
        write_word(pick_written(), $random(seed), $random(seed));
      else
        read_word(pick_written());
    end

    repeat (3) begin
      wait_refresh();
      read_word(pick_written());
    end
    end_run();
  end

endmodule

`default_nettype wire

/* vlog.f */
sdram_pkg.sv
sdram_req_if.sv
sdram_beat_if.sv
sdram_request_reg.sv
sdram_sequencer.sv
sdram_data_path.sv
sdram_ctrl.sv
sdram_chip_model.sv
tb_sdram_ctrl.sv

/* Bender.yml */
package:
  name: sdram_ctrl

sources:
  - sdram_pkg.sv
  - sdram_req_if.sv
  - sdram_beat_if.sv
  - sdram_request_reg.sv
  - sdram_sequencer.sv
  - sdram_data_path.sv
  - sdram_ctrl.sv
  - target: simulation
    files:
      - sdram_chip_model.sv
      - tb_sdram_ctrl.sv
